// File: rob_core.f
rob_pkg.sv
rob.sv
operand_lookup.sv
arch_regfile.sv
rob_core.sv
tb_clock_gen.sv
rob_core_checker.sv
rob_core_tb.sv

// File: Bender.yml
package:
  name: rob_core

sources:
  - rob_pkg.sv
  - rob.sv
  - operand_lookup.sv
  - arch_regfile.sv
  - rob_core.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - rob_core_checker.sv
      - rob_core_tb.sv

// File: rob_core_tb.sv
/*
 * ROB core testbench, LFSR traffic with CDB and squash, then drain
 * and a sweep of all registers, checked by the model in the checker
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb
    import rob_pkg::*;
();

    localparam logic [15:0] lfsr_seed     = 16'd65188;
    localparam logic [15:0] lfsr_taps     = 16'hB400;
    localparam int          run_cycles    = 3000;
    localparam int          reset_timeout = 100;
    localparam int          drain_timeout = 500;

    logic                 clock;
    logic                 reset;
    logic                 dp_valid;
    logic                 dp_has_dest;
    reg_idx_t             dp_dest;
    reg_idx_t             dp_src_a;
    reg_idx_t             dp_src_b;
    logic                 dp_ready;
    rob_tag_t             dp_tag;
    rob_tag_t             src_a_tag;
    logic                 src_a_ready;
    word_t                src_a_value;
    rob_tag_t             src_b_tag;
    logic                 src_b_ready;
    word_t                src_b_value;
    logic                 cdb_valid;
    rob_tag_t             cdb_tag;
    word_t                cdb_value;
    logic                 squash_valid;
    rob_tag_t             squash_tag;
    logic                 retire_valid;
    rob_tag_t             retire_tag;
    logic                 retire_has_dest;
    reg_idx_t             retire_dest;
    word_t                retire_value;
    logic [rob_depth-1:0] live_mask;
    logic [rob_depth-1:0] pending_mask;
    int                   error_count;
    int                   check_count;
    int                   timeout_count;
    logic [15:0]          lfsr_state;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    rob_core u_dut (.*);

    rob_core_checker u_checker (.*);

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] random_bits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // random set bit of mask, as a tag
    function automatic rob_tag_t pick_tag(logic [rob_depth-1:0] mask);
        int       start;
        int       idx;
        rob_tag_t tag;
        start = int'(random_bits(3));
        tag   = '0;
        for (int k = 0; k < rob_depth; k++) begin
            idx = (start + k) % rob_depth;
            if (tag == '0 && mask[idx]) begin
                tag = rob_tag_t'(idx + 1);
            end
        end
        return tag;
    endfunction

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////
    task automatic drive_idle();
        dp_valid     = 1'b0;
        cdb_valid    = 1'b0;
        squash_valid = 1'b0;
    endtask

    task automatic drive_random(input logic hold);
        reg_idx_t dest;
        // a waiting instruction keeps every field
        if (!hold) begin
            dp_valid    = (random_bits(2) != 0);
            dest        = reg_idx_t'(random_bits(5));
            dp_has_dest = random_bits(1) && dest != '0;
            dp_dest     = dest;
            dp_src_a    = reg_idx_t'(random_bits(5));
            dp_src_b    = reg_idx_t'(random_bits(5));
        end
        cdb_valid = 1'b0;
        if (pending_mask != '0 && random_bits(2) != 0) begin
            cdb_valid = 1'b1;
            cdb_tag   = pick_tag(pending_mask);
            cdb_value = random_bits(32);
        end
        // rare squash of a live entry
        squash_valid = 1'b0;
        if (live_mask != '0 && random_bits(5) == 0) begin
            squash_valid = 1'b1;
            squash_tag   = pick_tag(live_mask);
        end
    endtask

    ////////////////////////////////////////
    // phases
    ////////////////////////////////////////
    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (reset && waited < reset_timeout) begin
            @(posedge clock);
            waited++;
        end
        if (reset) begin
            $display("reset still asserted after %0d cycles", reset_timeout);
            timeout_count++;
        end
    endtask

    task automatic run_traffic();
        logic ready_seen;
        logic accepted;
        for (int cycle = 0; cycle < run_cycles; cycle++) begin
            // sample ready mid-cycle where it has settled
            @(negedge clock);
            ready_seen = dp_ready;
            @(posedge clock);
            #1;
            accepted = dp_valid && ready_seen && !squash_valid;
            drive_random(dp_valid && !accepted);
        end
    endtask

    // complete whatever is left and let the head retire it all
    task automatic drain_rob();
        int waited;
        waited = 0;
        while ((live_mask != '0 || !dp_ready) && waited < drain_timeout) begin
            @(posedge clock);
            #1;
            drive_idle();
            if (pending_mask != '0) begin
                cdb_valid = 1'b1;
                cdb_tag   = pick_tag(pending_mask);
                cdb_value = random_bits(32);
            end
            waited++;
        end
        drive_idle();
        if (live_mask != '0 || !dp_ready) begin
            $display("ROB did not drain within %0d cycles", drain_timeout);
            timeout_count++;
        end
    endtask

    // ROB is empty so every lookup reads the register file
    task automatic sweep_registers();
        for (int r = 0; r < reg_count; r++) begin
            @(posedge clock);
            #1;
            dp_src_a = reg_idx_t'(r);
            dp_src_b = reg_idx_t'(reg_count - 1 - r);
        end
        repeat (2) @(posedge clock);
    endtask

    initial begin
        lfsr_state    = lfsr_seed;
        timeout_count = 0;
        dp_valid      = 1'b0;
        dp_has_dest   = 1'b0;
        dp_dest       = '0;
        dp_src_a      = '0;
        dp_src_b      = '0;
        cdb_valid     = 1'b0;
        cdb_tag       = '0;
        cdb_value     = '0;
        squash_valid  = 1'b0;
        squash_tag    = '0;

        wait_reset_release();
        if (timeout_count == 0) begin
            run_traffic();
            drain_rob();
            sweep_registers();
        end

        $display("checks %0d, errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob_core_checker.sv
/*
 * ROB core checker, reference model of the ROB queue and register file
 * compares every DUT output on each rising edge before stepping the model
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core_checker
    import rob_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     dp_valid,
    input  wire logic     dp_has_dest,
    input  wire reg_idx_t dp_dest,
    input  wire reg_idx_t dp_src_a,
    input  wire reg_idx_t dp_src_b,
    input  wire logic     dp_ready,
    input  wire rob_tag_t dp_tag,
    input  wire rob_tag_t src_a_tag,
    input  wire logic     src_a_ready,
    input  wire word_t    src_a_value,
    input  wire rob_tag_t src_b_tag,
    input  wire logic     src_b_ready,
    input  wire word_t    src_b_value,
    input  wire logic     cdb_valid,
    input  wire rob_tag_t cdb_tag,
    input  wire word_t    cdb_value,
    input  wire logic     squash_valid,
    input  wire rob_tag_t squash_tag,
    input  wire logic     retire_valid,
    input  wire rob_tag_t retire_tag,
    input  wire logic     retire_has_dest,
    input  wire reg_idx_t retire_dest,
    input  wire word_t    retire_value,
    // model state for the stimulus, bit i is tag i+1
    output logic [rob_depth-1:0] live_mask,
    output logic [rob_depth-1:0] pending_mask,
    output int            error_count,
    output int            check_count
);

    // model entries indexed by tag minus one
    logic     m_has_dest [rob_depth];
    reg_idx_t m_dest     [rob_depth];
    logic     m_complete [rob_depth];
    word_t    m_value    [rob_depth];
    word_t    m_regs     [reg_count];
    int       m_head;
    int       m_tail;
    int       m_count;

    // retire report due on the next edge
    logic     exp_rv;
    int       exp_rtag;
    logic     exp_rhas;
    reg_idx_t exp_rdest;
    word_t    exp_rval;

    // tags 1..rob_depth, wrapping in both directions
    function automatic int step_tag(int tag, int delta);
        return ((tag - 1 + delta + 2 * rob_depth) % rob_depth) + 1;
    endfunction

    // distance from head, below m_count means live
    function automatic int live_offset(int tag);
        return (tag - m_head + rob_depth) % rob_depth;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error %s at %0t: expected %0h, actual %0h",
                     name, $time, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // operand rule
    ////////////////////////////////////////
    task automatic check_operand(input string which, input reg_idx_t src,
                                 input rob_tag_t tag, input logic ready, input word_t value);
        int    t;
        int    producer;
        logic  exp_ready;
        word_t exp_value;
        producer = 0;
        // youngest first, first hit wins
        for (int k = 1; k <= m_count; k++) begin
            t = step_tag(m_tail, -k);
            if (producer == 0 && src != '0 && m_has_dest[t-1] && m_dest[t-1] == src) begin
                producer = t;
            end
        end
        exp_ready = (producer == 0) || m_complete[producer-1];
        if (producer == 0) begin
            exp_value = (src == '0) ? '0 : m_regs[src];
        end else begin
            exp_value = m_value[producer-1];
        end
        compare_value({which, "_tag"}, exp_ready ? 32'd0 : 32'(producer), 32'(tag));
        compare_value({which, "_ready"}, 32'(exp_ready), 32'(ready));
        // value is only meaningful once ready
        if (exp_ready) begin
            compare_value({which, "_value"}, exp_value, value);
        end
    endtask

    task automatic update_masks();
        int t;
        live_mask    = '0;
        pending_mask = '0;
        for (int k = 0; k < m_count; k++) begin
            t = step_tag(m_head, k);
            live_mask[t-1] = 1'b1;
            pending_mask[t-1] = !m_complete[t-1];
        end
    endtask

    ////////////////////////////////////////
    // compare, then step the model
    ////////////////////////////////////////
    always @(posedge clock or posedge reset) begin : model_step
        logic ret_fire;
        logic dp_fire;
        logic cdb_hit;
        if (reset) begin
            m_head      = 1;
            m_tail      = 1;
            m_count     = 0;
            exp_rv      = 1'b0;
            error_count = 0;
            check_count = 0;
            for (int r = 0; r < reg_count; r++) begin
                m_regs[r] = '0;
            end
            update_masks();
        end else begin
            compare_value("dp_ready", 32'(m_count != rob_depth), 32'(dp_ready));
            compare_value("dp_tag", 32'(m_tail), 32'(dp_tag));
            check_operand("src_a", dp_src_a, src_a_tag, src_a_ready, src_a_value);
            check_operand("src_b", dp_src_b, src_b_tag, src_b_ready, src_b_value);
            compare_value("retire_valid", 32'(exp_rv), 32'(retire_valid));
            if (exp_rv) begin
                compare_value("retire_tag", 32'(exp_rtag), 32'(retire_tag));
                compare_value("retire_has_dest", 32'(exp_rhas), 32'(retire_has_dest));
                compare_value("retire_dest", 32'(exp_rdest), 32'(retire_dest));
                compare_value("retire_value", exp_rval, retire_value);
            end

            // decisions use the state before the edge
            ret_fire = m_count > 0 && m_complete[m_head-1] && !squash_valid;
            dp_fire  = dp_valid && m_count < rob_depth && !squash_valid;
            cdb_hit  = cdb_valid && cdb_tag >= 1 && cdb_tag <= rob_depth &&
                       live_offset(int'(cdb_tag)) < m_count;

            exp_rv = ret_fire;
            if (ret_fire) begin
                exp_rtag  = m_head;
                exp_rhas  = m_has_dest[m_head-1];
                exp_rdest = m_dest[m_head-1];
                exp_rval  = m_value[m_head-1];
                // register file written at the same edge
                if (exp_rhas) begin
                    m_regs[exp_rdest] = exp_rval;
                end
            end
            if (cdb_hit) begin
                m_complete[cdb_tag-1] = 1'b1;
                m_value[cdb_tag-1]    = cdb_value;
            end

            if (squash_valid) begin
                // survivors are the entries older than squash_tag
                m_count = live_offset(int'(squash_tag));
                m_tail  = squash_tag;
            end else begin
                if (ret_fire) begin
                    m_head  = step_tag(m_head, 1);
                    m_count = m_count - 1;
                end
                if (dp_fire) begin
                    m_has_dest[m_tail-1] = dp_has_dest;
                    m_dest[m_tail-1]     = dp_dest;
                    m_complete[m_tail-1] = 1'b0;
                    m_tail               = step_tag(m_tail, 1);
                    m_count              = m_count + 1;
                end
            end
            update_masks();
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/* testbench clock and reset, 4 ns period, reset held for 16 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // release just after an edge, away from the sampling point
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: rob_core.sv
/*
 * in-order bookkeeping top, ROB with operand lookup and register file
 */
`timescale 1ns/1ps
`default_nettype none

module rob_core
    import rob_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    // dispatch
    input  wire logic     dp_valid,
    input  wire logic     dp_has_dest,
    input  wire reg_idx_t dp_dest,
    input  wire reg_idx_t dp_src_a,
    input  wire reg_idx_t dp_src_b,
    output logic          dp_ready,
    output rob_tag_t      dp_tag,
    // operands
    output rob_tag_t      src_a_tag,
    output logic          src_a_ready,
    output word_t         src_a_value,
    output rob_tag_t      src_b_tag,
    output logic          src_b_ready,
    output word_t         src_b_value,
    // common data bus
    input  wire logic     cdb_valid,
    input  wire rob_tag_t cdb_tag,
    input  wire word_t    cdb_value,
    // squash
    input  wire logic     squash_valid,
    input  wire rob_tag_t squash_tag,
    // retire
    output logic          retire_valid,
    output rob_tag_t      retire_tag,
    output logic          retire_has_dest,
    output reg_idx_t      retire_dest,
    output word_t         retire_value
);

    rob_entries_t entries;
    rob_tag_t     tail;
    word_t        rf_a_value;
    word_t        rf_b_value;
    logic         commit_valid;
    logic         commit_has_dest;
    reg_idx_t     commit_dest;
    word_t        commit_value;

    ////////////////////////////////////////
    // reorder buffer
    ////////////////////////////////////////
    rob u_rob (
        .clock           (clock),
        .reset           (reset),
        .dp_valid        (dp_valid),
        .dp_has_dest     (dp_has_dest),
        .dp_dest         (dp_dest),
        .dp_ready        (dp_ready),
        .dp_tag          (dp_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .squash_valid    (squash_valid),
        .squash_tag      (squash_tag),
        .entries         (entries),
        .tail            (tail),
        .commit_valid    (commit_valid),
        .commit_has_dest (commit_has_dest),
        .commit_dest     (commit_dest),
        .commit_value    (commit_value),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .retire_has_dest (retire_has_dest),
        .retire_dest     (retire_dest),
        .retire_value    (retire_value)
    );

    // lookup sees entries and register file from before the edge
    operand_lookup u_lookup (
        .entries     (entries),
        .tail        (tail),
        .src_a       (dp_src_a),
        .src_b       (dp_src_b),
        .rf_a_value  (rf_a_value),
        .rf_b_value  (rf_b_value),
        .src_a_tag   (src_a_tag),
        .src_a_ready (src_a_ready),
        .src_a_value (src_a_value),
        .src_b_tag   (src_b_tag),
        .src_b_ready (src_b_ready),
        .src_b_value (src_b_value)
    );

    // written on the edge the head entry leaves the ROB
    arch_regfile u_regfile (
        .clock        (clock),
        .reset        (reset),
        .write_enable (commit_valid & commit_has_dest),
        .write_idx    (commit_dest),
        .write_value  (commit_value),
        .read_a_idx   (dp_src_a),
        .read_b_idx   (dp_src_b),
        .read_a_value (rf_a_value),
        .read_b_value (rf_b_value)
    );

endmodule

`default_nettype wire

// File: arch_regfile.sv
/*
 * architectural register file, 31 writable registers plus hardwired zero
 * one retire write port, two combinational read ports
 */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
    import rob_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    // retire write
    input  wire logic     write_enable,
    input  wire reg_idx_t write_idx,
    input  wire word_t    write_value,
    // dispatch reads
    input  wire reg_idx_t read_a_idx,
    input  wire reg_idx_t read_b_idx,
    output word_t         read_a_value,
    output word_t         read_b_value
);

    // r0 has no storage
    word_t regs [1:reg_count-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_idx != '0) begin
            regs[write_idx] <= write_value;
        end
    end

    // no write bypass, the value shows up the cycle after retire
    assign read_a_value = (read_a_idx == '0) ? '0 : regs[read_a_idx];
    assign read_b_value = (read_b_idx == '0) ? '0 : regs[read_b_idx];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    // dispatch never allocates r0 as a destination, so retire never writes it
    no_write_to_r0: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> (write_idx != '0));

endmodule

`default_nettype wire

// File: operand_lookup.sv
/*
 * operand lookup, youngest in-flight producer search per source
 * picks a pending tag, a forwarded ROB value or the register file value
 */
`timescale 1ns/1ps
`default_nettype none

module operand_lookup
    import rob_pkg::*;
(
    input  wire rob_entries_t entries,
    input  wire rob_tag_t     tail,
    input  wire reg_idx_t     src_a,
    input  wire reg_idx_t     src_b,
    input  wire word_t        rf_a_value,
    input  wire word_t        rf_b_value,
    output rob_tag_t          src_a_tag,
    output logic              src_a_ready,
    output word_t             src_a_value,
    output rob_tag_t          src_b_tag,
    output logic              src_b_ready,
    output word_t             src_b_value
);

    typedef struct packed {
        rob_tag_t tag;
        logic     ready;
        word_t    value;
    } operand_t;

    ////////////////////////////////////////
    // producer search
    ////////////////////////////////////////
    // returns tag 0 when no live entry writes src
    function automatic rob_tag_t find_producer(rob_entries_t ents, rob_tag_t tl,
                                               reg_idx_t src);
        rob_idx_t idx;
        rob_tag_t found;
        found = '0;
        // walk oldest to youngest, last match wins
        // k = rob_depth lands on the tail slot, the head when full
        for (int k = rob_depth; k >= 1; k--) begin
            idx = tag_index(tl) - rob_idx_t'(k);
            if (ents[idx].valid && ents[idx].has_dest &&
                ents[idx].dest == src && src != '0) begin
                found = index_tag(idx);
            end
        end
        return found;
    endfunction

    function automatic operand_t resolve(rob_entries_t ents, rob_tag_t tl,
                                         reg_idx_t src, word_t rf_value);
        rob_tag_t   prod;
        rob_entry_t ent;
        operand_t   res;
        prod = find_producer(ents, tl, src);
        ent  = ents[tag_index(prod)];
        if (prod == '0) begin
            // no producer in flight, architectural value
            res.tag   = '0;
            res.ready = 1'b1;
            res.value = (src == '0) ? '0 : rf_value;
        end else if (ent.complete) begin
            // done but not yet retired, forward
            res.tag   = '0;
            res.ready = 1'b1;
            res.value = ent.value;
        end else begin
            // still executing, wait on its tag
            res.tag   = prod;
            res.ready = 1'b0;
            res.value = '0;
        end
        return res;
    endfunction

    operand_t op_a;
    operand_t op_b;

    always_comb begin
        op_a = resolve(entries, tail, src_a, rf_a_value);
        op_b = resolve(entries, tail, src_b, rf_b_value);
    end

    assign src_a_tag   = op_a.tag;
    assign src_a_ready = op_a.ready;
    assign src_a_value = op_a.value;
    assign src_b_tag   = op_b.tag;
    assign src_b_ready = op_b.ready;
    assign src_b_value = op_b.value;

endmodule

`default_nettype wire

// File: rob.sv
/*
 * reorder buffer, 8-entry circular queue with an occupancy count
 * handles dispatch, CDB completion, in-order retirement and squash
 */
`timescale 1ns/1ps
`default_nettype none

module rob
    import rob_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    // dispatch
    input  wire logic         dp_valid,
    input  wire logic         dp_has_dest,
    input  wire reg_idx_t     dp_dest,
    output logic              dp_ready,
    output rob_tag_t          dp_tag,
    // common data bus
    input  wire logic         cdb_valid,
    input  wire rob_tag_t     cdb_tag,
    input  wire word_t        cdb_value,
    // squash
    input  wire logic         squash_valid,
    input  wire rob_tag_t     squash_tag,
    // state for operand lookup
    output rob_entries_t      entries,
    output rob_tag_t          tail,
    // same-edge commit to the register file
    output logic              commit_valid,
    output logic              commit_has_dest,
    output reg_idx_t          commit_dest,
    output word_t             commit_value,
    // registered retire report
    output logic              retire_valid,
    output rob_tag_t          retire_tag,
    output logic              retire_has_dest,
    output reg_idx_t          retire_dest,
    output word_t             retire_value
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    // control bits cleared on reset
    logic [rob_depth-1:0] valid_q;
    logic [rob_depth-1:0] complete_q;
    rob_tag_t             head;
    rob_count_t           count;

    // payload
    logic                 has_dest_q [rob_depth];
    reg_idx_t             dest_q     [rob_depth];
    word_t                value_q    [rob_depth];

    rob_idx_t head_idx;
    rob_idx_t tail_idx;
    rob_idx_t cdb_idx;
    rob_idx_t sq_offset;
    logic     dp_fire;
    logic     retire_fire;
    logic     cdb_hit;

    assign head_idx  = tag_index(head);
    assign tail_idx  = tag_index(tail);
    assign cdb_idx   = tag_index(cdb_tag);
    // distance of the squashed entry from head = survivors left
    assign sq_offset = tag_index(squash_tag) - head_idx;

    assign dp_ready = (count != rob_count_t'(rob_depth));
    assign dp_tag   = tail;

    // squash blocks both ends of the queue for one cycle
    assign dp_fire     = dp_valid && dp_ready && !squash_valid;
    assign retire_fire = valid_q[head_idx] && complete_q[head_idx] && !squash_valid;

    // out-of-range or free tags are dropped
    assign cdb_hit = cdb_valid && (cdb_tag != '0) &&
                     (cdb_tag <= rob_tag_t'(rob_depth)) && valid_q[cdb_idx];

    // head entry goes straight to the register file
    assign commit_valid    = retire_fire;
    assign commit_has_dest = has_dest_q[head_idx];
    assign commit_dest     = dest_q[head_idx];
    assign commit_value    = value_q[head_idx];

    always_comb begin
        for (int i = 0; i < rob_depth; i++) begin
            entries[i] = '{valid:    valid_q[i],
                           has_dest: has_dest_q[i],
                           dest:     dest_q[i],
                           complete: complete_q[i],
                           value:    value_q[i]};
        end
    end

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q      <= '0;
            complete_q   <= '0;
            head         <= rob_tag_t'(1);
            tail         <= rob_tag_t'(1);
            count        <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_fire;

            // completion survives a squash of younger entries
            if (cdb_hit) begin
                complete_q[cdb_idx] <= 1'b1;
            end

            if (squash_valid) begin
                // drop the named entry and everything after it
                for (int i = 0; i < rob_depth; i++) begin
                    if (rob_idx_t'(i) - head_idx >= sq_offset) begin
                        valid_q[i] <= 1'b0;
                    end
                end
                tail  <= squash_tag;
                count <= {1'b0, sq_offset};
            end else begin
                if (retire_fire) begin
                    valid_q[head_idx] <= 1'b0;
                    head              <= next_tag(head);
                end
                // tail slot is free here, so no clash with retire or cdb
                if (dp_fire) begin
                    valid_q[tail_idx]    <= 1'b1;
                    complete_q[tail_idx] <= 1'b0;
                    tail                 <= next_tag(tail);
                end
                if (dp_fire && !retire_fire) begin
                    count <= count + rob_count_t'(1);
                end else if (retire_fire && !dp_fire) begin
                    count <= count - rob_count_t'(1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (dp_fire) begin
            has_dest_q[tail_idx] <= dp_has_dest;
            dest_q[tail_idx]     <= dp_dest;
        end
        if (cdb_hit) begin
            value_q[cdb_idx] <= cdb_value;
        end
        // retire report qualified by retire_valid
        if (retire_fire) begin
            retire_tag      <= head;
            retire_has_dest <= has_dest_q[head_idx];
            retire_dest     <= dest_q[head_idx];
            retire_value    <= value_q[head_idx];
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    // execution only broadcasts tags it was handed at dispatch
    cdb_targets_live_entry: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (cdb_tag != '0 && cdb_tag <= rob_tag_t'(rob_depth) &&
                       valid_q[cdb_idx]));

    // branch unit squashes only instructions still in flight
    squash_targets_live_entry: assert property (@(posedge clock) disable iff (reset)
        squash_valid |-> (squash_tag != '0 && squash_tag <= rob_tag_t'(rob_depth) &&
                          valid_q[tag_index(squash_tag)]));

    // an accepted dispatch always lands on a free slot
    dispatch_into_free_slot: assert property (@(posedge clock) disable iff (reset)
        dp_fire |-> !valid_q[tail_idx]);

endmodule

`default_nettype wire

// File: rob_pkg.sv
/*
 * reorder buffer package
 * sizes, tag and register types, ROB entry layout and tag helpers
 */
`default_nettype none

package rob_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int rob_depth     = 8;
    localparam int tag_width     = 4;
    localparam int idx_width     = 3;
    localparam int reg_count     = 32;
    localparam int reg_idx_width = 5;
    localparam int word_width    = 32;

    // tag 0 means no producer, live tags run 1..rob_depth
    typedef logic [tag_width-1:0]     rob_tag_t;
    // storage slot, tag minus one
    typedef logic [idx_width-1:0]     rob_idx_t;
    // occupancy, 0..rob_depth
    typedef logic [tag_width-1:0]     rob_count_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;
    typedef logic [word_width-1:0]    word_t;

    typedef struct packed {
        logic     valid;
        logic     has_dest;
        reg_idx_t dest;
        logic     complete;
        word_t    value;
    } rob_entry_t;

    // slot i holds tag i+1
    typedef rob_entry_t [rob_depth-1:0] rob_entries_t;

    ////////////////////////////////////////
    // tag arithmetic
    ////////////////////////////////////////
    function automatic rob_idx_t tag_index(rob_tag_t tag);
        rob_tag_t slot;
        slot = tag - rob_tag_t'(1);
        return slot[idx_width-1:0];
    endfunction

    function automatic rob_tag_t index_tag(rob_idx_t idx);
        return {1'b0, idx} + rob_tag_t'(1);
    endfunction

    // wraps from rob_depth back to 1
    function automatic rob_tag_t next_tag(rob_tag_t tag);
        return (tag == rob_tag_t'(rob_depth)) ? rob_tag_t'(1) : tag + rob_tag_t'(1);
    endfunction

endpackage

`default_nettype wire
